// File: src/ucpd_rx_pkg.sv
// ucpd_rx_pkg
// shared types, K-code values, ordered-set codes and the 4b5b
// symbol table for the USB PD receive path

package ucpd_rx_pkg;

  // ----------------------------------------
  // widths and types
  // ----------------------------------------
  localparam int SYM_W      = 5;
  localparam int NIB_W      = 4;
  localparam int BYTE_W     = 8;
  localparam int WIN_W      = 4 * SYM_W;  // four symbols of an ordered set
  localparam int ORDSET_NUM = 6;          // enable bits, SOP up to Cable Reset

  typedef logic [SYM_W-1:0]  symbol_t;
  typedef logic [NIB_W-1:0]  nibble_t;
  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WIN_W-1:0]  window_t;    // K1 in the low bits
  typedef logic [2:0]        corrupt_idx_t;  // 0 none, 1 to 4 corrupted slot

  typedef enum logic [2:0] {
    ORD_SOP       = 3'd0,
    ORD_SOP1      = 3'd1,  // SOP'
    ORD_SOP2      = 3'd2,  // SOP''
    ORD_SOP1_DBG  = 3'd3,  // SOP'_Debug
    ORD_SOP2_DBG  = 3'd4,  // SOP''_Debug
    ORD_CABLE_RST = 3'd5,
    ORD_HARD_RST  = 3'd6
  } ordset_e;

  // ----------------------------------------
  // K-codes
  // ----------------------------------------
  // bit 0 of every symbol is the first one on the line
  localparam symbol_t K_SYNC1 = 5'b11000;
  localparam symbol_t K_SYNC2 = 5'b10001;
  localparam symbol_t K_SYNC3 = 5'b00110;
  localparam symbol_t K_RST1  = 5'b00111;
  localparam symbol_t K_RST2  = 5'b11001;
  localparam symbol_t K_EOP   = 5'b01101;

  // ----------------------------------------
  // 4b5b data symbols
  // ----------------------------------------
  localparam symbol_t SYM_TABLE [16] = '{
    5'b11110,  // 0
    5'b01001,  // 1
    5'b10100,  // 2
    5'b10101,  // 3
    5'b01010,  // 4
    5'b01011,  // 5
    5'b01110,  // 6
    5'b01111,  // 7
    5'b10010,  // 8
    5'b10011,  // 9
    5'b10110,  // a
    5'b10111,  // b
    5'b11010,  // c
    5'b11011,  // d
    5'b11100,  // e
    5'b11101   // f
  };

  function automatic symbol_t encode_4b5b(input nibble_t nib);
    return SYM_TABLE[nib];
  endfunction

  // returns 1 when sym is a data symbol, nib carries its value
  function automatic logic decode_4b5b(input symbol_t sym, output nibble_t nib);
    logic found;
    found = 1'b0;
    nib   = '0;
    for (int i = 0; i < 16; i++)
    begin
      if (SYM_TABLE[i] == sym)
      begin
        found = 1'b1;
        nib   = nibble_t'(i);
      end
    end
    return found;
  endfunction

endpackage

// File: src/ucpd_rx_kcode_window.sv
`timescale 1ns/10ps

// ucpd_rx_kcode_window
// keeps the last four line symbols in a shift register and counts
// bits modulo five so that symbol boundaries are known after align

module ucpd_rx_kcode_window (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 bit_valid,
  input  logic                 bit_data,
  input  logic                 line_idle,
  input  logic                 align,
  output ucpd_rx_pkg::window_t window,
  output logic                 window_vld,
  output logic                 sym_vld
);

  logic [2:0] bit_cnt;  // bits of the current symbol

  // ----------------------------------------
  // window shift
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      window     <= '0;
      window_vld <= 1'b0;
    end
    else if (line_idle)
    begin
      window     <= '0;
      window_vld <= 1'b0;
    end
    else
    begin
      window_vld <= bit_valid;
      if (bit_valid)
        window <= {bit_data, window[ucpd_rx_pkg::WIN_W-1:1]};  // oldest bits drift to K1
    end
  end

  // ----------------------------------------
  // symbol boundary
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      bit_cnt <= '0;
      sym_vld <= 1'b0;
    end
    else
    begin
      sym_vld <= 1'b0;
      if (line_idle || align)
        bit_cnt <= '0;  // next bit starts a symbol
      else if (bit_valid)
      begin
        if (bit_cnt == 3'd4)
        begin
          bit_cnt <= '0;
          sym_vld <= 1'b1;  // K4 slot holds a whole symbol
        end
        else
          bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

endmodule

// File: src/ucpd_rx_ordset_detect.sv
`timescale 1ns/10ps

// ucpd_rx_ordset_detect
// compares the symbol window with every ordered set and reports the
// enabled type with the lowest code that matches at least three slots

module ucpd_rx_ordset_detect (
  input  logic                                ucpd_clk,
  input  logic                                ic_rst_n,
  input  logic                                window_vld,
  input  ucpd_rx_pkg::window_t                window,
  input  logic [ucpd_rx_pkg::ORDSET_NUM-1:0]  ordset_en,
  output logic                                hit,
  output ucpd_rx_pkg::ordset_e                hit_type,
  output ucpd_rx_pkg::corrupt_idx_t           hit_idx
);

  localparam int SYM_W     = ucpd_rx_pkg::SYM_W;
  localparam int NUM_TYPES = ucpd_rx_pkg::ORDSET_NUM + 1;  // hard reset on top

  // reference sets in line order K1 to K4, indexed by enum code
  localparam ucpd_rx_pkg::symbol_t ORDSET_REF [NUM_TYPES][4] = '{
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC1,
      ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC2},  // SOP
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC1,
      ucpd_rx_pkg::K_SYNC3, ucpd_rx_pkg::K_SYNC3},  // SOP'
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC3,
      ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC3},  // SOP''
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_RST2,
      ucpd_rx_pkg::K_RST2,  ucpd_rx_pkg::K_SYNC3},  // SOP'_Debug
    '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_RST2,
      ucpd_rx_pkg::K_SYNC3, ucpd_rx_pkg::K_SYNC2},  // SOP''_Debug
    '{ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_SYNC1,
      ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_SYNC3},  // Cable Reset
    '{ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_RST1,
      ucpd_rx_pkg::K_RST1,  ucpd_rx_pkg::K_RST2}    // Hard Reset
  };

  logic [3:0]                slot_eq [NUM_TYPES];  // per type, one bit per slot
  logic [NUM_TYPES-1:0]      type_en;
  logic [NUM_TYPES-1:0]      type_match;
  logic                      hit_nxt;
  ucpd_rx_pkg::ordset_e      type_nxt;
  ucpd_rx_pkg::corrupt_idx_t idx_nxt;

  // slot that disagrees, 0 when all four agree
  function automatic ucpd_rx_pkg::corrupt_idx_t bad_slot(input logic [3:0] eq);
    case (eq)
      4'b1110 : return 3'd1;
      4'b1101 : return 3'd2;
      4'b1011 : return 3'd3;
      4'b0111 : return 3'd4;
      default : return 3'd0;
    endcase
  endfunction

  assign type_en = {1'b1, ordset_en};  // hard reset is always searched

  // ----------------------------------------
  // three of four match
  // ----------------------------------------
  always_comb
  begin
    for (int t = 0; t < NUM_TYPES; t++)
    begin
      for (int s = 0; s < 4; s++)
        slot_eq[t][s] = (window[s*SYM_W +: SYM_W] == ORDSET_REF[t][s]);
      type_match[t] = type_en[t] && ($countones(slot_eq[t]) >= 3);
    end
  end

  // lowest code wins, so walk down and let it overwrite
  always_comb
  begin
    hit_nxt  = 1'b0;
    type_nxt = ucpd_rx_pkg::ORD_SOP;
    idx_nxt  = '0;
    for (int t = NUM_TYPES - 1; t >= 0; t--)
    begin
      if (type_match[t])
      begin
        hit_nxt  = 1'b1;
        type_nxt = ucpd_rx_pkg::ordset_e'(t[2:0]);
        idx_nxt  = bad_slot(slot_eq[t]);
      end
    end
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      hit <= 1'b0;
    else
      hit <= window_vld && hit_nxt;
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (window_vld)
    begin
      hit_type <= type_nxt;
      hit_idx  <= idx_nxt;
    end
  end

endmodule

// File: src/ucpd_rx_framer.sv
`timescale 1ns/10ps

// ucpd_rx_framer
// hunts for an ordered set, then decodes each symbol of the message
// to a nibble until EOP or a bad symbol ends it

module ucpd_rx_framer (
  input  logic                      ucpd_clk,
  input  logic                      ic_rst_n,
  input  logic                      line_idle,
  input  logic                      hit,
  input  logic                      sym_vld,
  input  ucpd_rx_pkg::ordset_e      hit_type,
  input  ucpd_rx_pkg::corrupt_idx_t hit_idx,
  input  ucpd_rx_pkg::window_t      window,
  output logic                      align,
  output logic                      nib_vld,
  output logic                      msg_start,
  output logic                      ordset_vld,
  output logic                      hrst_det,
  output logic                      msg_end,
  output logic                      rx_data_err,
  output ucpd_rx_pkg::nibble_t      nib,
  output ucpd_rx_pkg::ordset_e      ordset_type,
  output ucpd_rx_pkg::corrupt_idx_t sop_corrupt_idx
);

  typedef enum logic [1:0] {HUNT, DATA, IDLE_WAIT} state_e;

  state_e               state;
  ucpd_rx_pkg::symbol_t sym_q;      // symbol taken from the K4 slot
  logic                 sym_q_vld;
  logic                 dec_ok;
  ucpd_rx_pkg::nibble_t dec_nib;
  logic                 is_reset;

  assign is_reset = (hit_type == ucpd_rx_pkg::ORD_HARD_RST) ||
                    (hit_type == ucpd_rx_pkg::ORD_CABLE_RST);

  // ----------------------------------------
  // symbol capture and decode
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      sym_q_vld <= 1'b0;
    else
      sym_q_vld <= sym_vld && (state == DATA) && !line_idle;
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (sym_vld)
      sym_q <= window[ucpd_rx_pkg::WIN_W-1 -: ucpd_rx_pkg::SYM_W];
    if (sym_q_vld)
      nib <= dec_nib;
  end

  always_comb
  begin
    dec_ok = ucpd_rx_pkg::decode_4b5b(sym_q, dec_nib);
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      state           <= HUNT;
      align           <= 1'b0;
      msg_start       <= 1'b0;
      nib_vld         <= 1'b0;
      ordset_vld      <= 1'b0;
      hrst_det        <= 1'b0;
      msg_end         <= 1'b0;
      rx_data_err     <= 1'b0;
      ordset_type     <= ucpd_rx_pkg::ORD_SOP;
      sop_corrupt_idx <= '0;
    end
    else
    begin
      align       <= 1'b0;
      msg_start   <= 1'b0;
      nib_vld     <= 1'b0;
      ordset_vld  <= 1'b0;
      hrst_det    <= 1'b0;
      msg_end     <= 1'b0;
      rx_data_err <= 1'b0;
      if (line_idle)
        state <= HUNT;  // abort whatever is in progress
      else
        case (state)
          HUNT :
            if (hit)
            begin
              ordset_type     <= hit_type;
              sop_corrupt_idx <= hit_idx;
              if (hit_type == ucpd_rx_pkg::ORD_HARD_RST)
                hrst_det <= 1'b1;
              else
                ordset_vld <= 1'b1;
              if (!is_reset)
              begin
                state     <= DATA;
                align     <= 1'b1;  // restart the symbol count
                msg_start <= 1'b1;
              end
            end
          DATA :
            if (sym_q_vld)
            begin
              if (dec_ok)
                nib_vld <= 1'b1;
              else if (sym_q == ucpd_rx_pkg::K_EOP)
              begin
                msg_end <= 1'b1;
                state   <= IDLE_WAIT;
              end
              else
              begin
                rx_data_err <= 1'b1;
                state       <= IDLE_WAIT;
              end
            end
          default : ;  // wait for the line to go idle
        endcase
    end
  end

endmodule

// File: src/ucpd_rx_byte_assembler.sv
`timescale 1ns/10ps

// ucpd_rx_byte_assembler
// packs nibbles low half first into bytes and keeps the one-deep
// receive data register with its not-empty and overflow flags

module ucpd_rx_byte_assembler #(
  parameter int PAYSIZE_W = 10
) (
  input  logic                 ucpd_clk,
  input  logic                 ic_rst_n,
  input  logic                 nib_vld,
  input  logic                 msg_start,
  input  logic                 rxdr_rd,
  input  ucpd_rx_pkg::nibble_t nib,
  output ucpd_rx_pkg::byte_t   rxdr,
  output logic                 rxne,
  output logic                 rx_ovrflow,
  output logic [PAYSIZE_W-1:0] paysize
);

  logic                 nib_hi;     // next nibble is the upper half
  ucpd_rx_pkg::nibble_t nib_lo;
  logic                 byte_done;
  logic                 byte_wr;    // register free or read in this cycle
  ucpd_rx_pkg::byte_t   byte_nxt;

  assign byte_done = nib_vld && nib_hi;
  assign byte_wr   = byte_done && (!rxne || rxdr_rd);
  assign byte_nxt  = {nib, nib_lo};

  // ----------------------------------------
  // nibble pairing
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
      nib_hi <= 1'b0;
    else if (msg_start)
      nib_hi <= 1'b0;
    else if (nib_vld)
      nib_hi <= !nib_hi;
  end

  always_ff @(posedge ucpd_clk)
  begin
    if (nib_vld && !nib_hi)
      nib_lo <= nib;
    if (byte_wr)
      rxdr <= byte_nxt;
  end

  // ----------------------------------------
  // rxdr status and payload count
  // ----------------------------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n)
  begin
    if (!ic_rst_n)
    begin
      rxne       <= 1'b0;
      rx_ovrflow <= 1'b0;
      paysize    <= '0;
    end
    else
    begin
      rx_ovrflow <= byte_done && rxne && !rxdr_rd;  // byte lost
      if (byte_wr)
        rxne <= 1'b1;
      else if (rxdr_rd)
        rxne <= 1'b0;
      if (msg_start)
        paysize <= '0;
      else if (byte_done)
        paysize <= paysize + PAYSIZE_W'(1);  // dropped bytes count too
    end
  end

endmodule

// File: src/ucpd_rx_top.sv
`timescale 1ns/10ps

// ucpd_rx_top
// USB PD receive path from decoded BMC bits to the receive data
// register with ordered-set, end of message and error events

module ucpd_rx_top #(
  parameter int PAYSIZE_W = 10
) (
  input  logic                               ucpd_clk,
  input  logic                               ic_rst_n,
  input  logic                               bit_valid,
  input  logic                               bit_data,
  input  logic                               line_idle,
  input  logic [ucpd_rx_pkg::ORDSET_NUM-1:0] ordset_en,
  input  logic                               rxdr_rd,
  output ucpd_rx_pkg::byte_t                 rxdr,
  output logic                               rxne,
  output logic                               rx_ovrflow,
  output logic [PAYSIZE_W-1:0]               paysize,
  output logic                               ordset_vld,
  output logic                               hrst_det,
  output ucpd_rx_pkg::ordset_e               ordset_type,
  output ucpd_rx_pkg::corrupt_idx_t          sop_corrupt_idx,
  output logic                               msg_end,
  output logic                               rx_data_err
);

  ucpd_rx_pkg::window_t      window;
  logic                      window_vld;
  logic                      sym_vld;
  logic                      align;
  logic                      hit;
  ucpd_rx_pkg::ordset_e      hit_type;
  ucpd_rx_pkg::corrupt_idx_t hit_idx;
  logic                      nib_vld;
  logic                      msg_start;
  ucpd_rx_pkg::nibble_t      nib;

  ucpd_rx_kcode_window ucpd_rx_kcode_window_inst (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .bit_valid  (bit_valid),
    .bit_data   (bit_data),
    .line_idle  (line_idle),
    .align      (align),
    .window     (window),
    .window_vld (window_vld),
    .sym_vld    (sym_vld)
  );

  ucpd_rx_ordset_detect ucpd_rx_ordset_detect_inst (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .window_vld (window_vld),
    .window     (window),
    .ordset_en  (ordset_en),
    .hit        (hit),
    .hit_type   (hit_type),
    .hit_idx    (hit_idx)
  );

  ucpd_rx_framer ucpd_rx_framer_inst (
    .ucpd_clk        (ucpd_clk),
    .ic_rst_n        (ic_rst_n),
    .line_idle       (line_idle),
    .hit             (hit),
    .sym_vld         (sym_vld),
    .hit_type        (hit_type),
    .hit_idx         (hit_idx),
    .window          (window),
    .align           (align),
    .nib_vld         (nib_vld),
    .msg_start       (msg_start),
    .ordset_vld      (ordset_vld),
    .hrst_det        (hrst_det),
    .msg_end         (msg_end),
    .rx_data_err     (rx_data_err),
    .nib             (nib),
    .ordset_type     (ordset_type),
    .sop_corrupt_idx (sop_corrupt_idx)
  );

  ucpd_rx_byte_assembler #(
    .PAYSIZE_W (PAYSIZE_W)
  ) ucpd_rx_byte_assembler_inst (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .nib_vld    (nib_vld),
    .msg_start  (msg_start),
    .rxdr_rd    (rxdr_rd),
    .nib        (nib),
    .rxdr       (rxdr),
    .rxne       (rxne),
    .rx_ovrflow (rx_ovrflow),
    .paysize    (paysize)
  );

endmodule

// File: bench/ucpd_rx_sva.sv
`timescale 1ns/10ps

// ucpd_rx_sva
// protocol assertions on the receive path outputs, bound to the top

module ucpd_rx_sva (
  input logic ucpd_clk,
  input logic ic_rst_n,
  input logic ordset_vld,
  input logic hrst_det,
  input logic msg_end,
  input logic rx_data_err,
  input logic rx_ovrflow,
  input logic rxne
);

  // ----------------------------------------
  // event pulses last one cycle
  // ----------------------------------------
  a_ordset_pulse : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    ordset_vld |=> !ordset_vld) else $error("ordset_vld wider than one cycle");
  a_hrst_pulse : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    hrst_det |=> !hrst_det) else $error("hrst_det wider than one cycle");
  a_end_pulse : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    msg_end |=> !msg_end) else $error("msg_end wider than one cycle");
  a_err_pulse : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_data_err |=> !rx_data_err) else $error("rx_data_err wider than one cycle");

  a_ovf_full : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_ovrflow |-> rxne) else $error("overflow with empty data register");
  a_set_excl : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    !(ordset_vld && hrst_det)) else $error("ordset_vld and hrst_det together");

endmodule

bind ucpd_rx_top ucpd_rx_sva ucpd_rx_sva_inst (.*);

// File: bench/tb_ucpd_rx.sv
`timescale 1ns/10ps

// tb_ucpd_rx
// directed testbench for the USB PD receive path, encodes ordered sets
// and 4b5b data onto the bit stream and checks the receiver's events

module tb_ucpd_rx;

  localparam int PAYSIZE_W  = 10;
  localparam int CLK_PERIOD = 40;
  localparam int BIT_CYCLES = 5;
  localparam int PRE_BITS   = 16;
  localparam int SET_BITS   = PRE_BITS + 20;
  localparam int TEST_BITS  = 2 * (SET_BITS + 85) + 6 * SET_BITS + 2 * (SET_BITS + 10)
                              + (SET_BITS + 35) + 2 * (SET_BITS + 15);
  localparam longint TIMEOUT_NS = longint'(TEST_BITS) * BIT_CYCLES * CLK_PERIOD * 3 / 2;

  logic                               ucpd_clk = 1'b0;
  logic                               ic_rst_n;
  logic                               bit_valid;
  logic                               bit_data;
  logic                               line_idle;
  logic [ucpd_rx_pkg::ORDSET_NUM-1:0] ordset_en;
  logic                               rxdr_rd;
  ucpd_rx_pkg::byte_t                 rxdr;
  logic                               rxne;
  logic                               rx_ovrflow;
  logic [PAYSIZE_W-1:0]               paysize;
  logic                               ordset_vld;
  logic                               hrst_det;
  ucpd_rx_pkg::ordset_e               ordset_type;
  ucpd_rx_pkg::corrupt_idx_t          sop_corrupt_idx;
  logic                               msg_end;
  logic                               rx_data_err;

  int          errors = 0;
  int          ordset_cnt = 0;   // event pulses seen so far
  int          hrst_cnt = 0;
  int          end_cnt = 0;
  int          data_err_cnt = 0;
  int          ovf_cnt = 0;
  logic [31:0] rng_state = 32'ha750_257f;

  ucpd_rx_top ucpd_rx_top_inst (.*);

  always #(CLK_PERIOD / 2) ucpd_clk = !ucpd_clk;

  // pulses are counted away from the rising edge
  always @(negedge ucpd_clk)
  begin
    if (ordset_vld) ordset_cnt++;
    if (hrst_det) hrst_cnt++;
    if (msg_end) end_cnt++;
    if (rx_data_err) data_err_cnt++;
    if (rx_ovrflow) ovf_cnt++;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic ucpd_rx_pkg::byte_t next_byte();
    rng_state = xorshift(rng_state);
    return rng_state[7:0];
  endfunction

  // K-codes of each ordered set, K1 first on the line
  task automatic ordset_codes(input ucpd_rx_pkg::ordset_e t, output ucpd_rx_pkg::symbol_t ks[4]);
    case (t)
      ucpd_rx_pkg::ORD_SOP       : ks = '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC1,
                                          ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC2};
      ucpd_rx_pkg::ORD_SOP1      : ks = '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC1,
                                          ucpd_rx_pkg::K_SYNC3, ucpd_rx_pkg::K_SYNC3};
      ucpd_rx_pkg::ORD_SOP2      : ks = '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC3,
                                          ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_SYNC3};
      ucpd_rx_pkg::ORD_SOP1_DBG  : ks = '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_RST2,
                                          ucpd_rx_pkg::K_RST2, ucpd_rx_pkg::K_SYNC3};
      ucpd_rx_pkg::ORD_SOP2_DBG  : ks = '{ucpd_rx_pkg::K_SYNC1, ucpd_rx_pkg::K_RST2,
                                          ucpd_rx_pkg::K_SYNC3, ucpd_rx_pkg::K_SYNC2};
      ucpd_rx_pkg::ORD_CABLE_RST : ks = '{ucpd_rx_pkg::K_RST1, ucpd_rx_pkg::K_SYNC1,
                                          ucpd_rx_pkg::K_RST1, ucpd_rx_pkg::K_SYNC3};
      default                    : ks = '{ucpd_rx_pkg::K_RST1, ucpd_rx_pkg::K_RST1,
                                          ucpd_rx_pkg::K_RST1, ucpd_rx_pkg::K_RST2};
    endcase
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge ucpd_clk);
    #2;
  endtask

  task automatic send_bit(input logic b);
    bit_valid = 1'b1;
    bit_data  = b;
    wait_cycles(1);
    bit_valid = 1'b0;
    wait_cycles(BIT_CYCLES - 1);
  endtask

  task automatic send_symbol(input ucpd_rx_pkg::symbol_t s);
    for (int i = 0; i < 5; i++)
      send_bit(s[i]);  // lsb first
  endtask

  task automatic send_preamble();
    for (int i = 0; i < PRE_BITS; i++)
      send_bit(i[0]);
  endtask

  task automatic send_ordset(input ucpd_rx_pkg::symbol_t ks[4]);
    send_preamble();
    for (int i = 0; i < 4; i++)
      send_symbol(ks[i]);
  endtask

  task automatic send_byte(input ucpd_rx_pkg::byte_t b);
    send_symbol(ucpd_rx_pkg::encode_4b5b(b[3:0]));
    send_symbol(ucpd_rx_pkg::encode_4b5b(b[7:4]));
  endtask

  task automatic idle_line();
    line_idle = 1'b1;
    wait_cycles(3);
    line_idle = 1'b0;
    wait_cycles(1);
  endtask

  task automatic read_rxdr();
    rxdr_rd = 1'b1;
    wait_cycles(1);
    rxdr_rd = 1'b0;
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_byte(input string name, input ucpd_rx_pkg::byte_t got,
                            input ucpd_rx_pkg::byte_t exp);
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_ordset(input string name, input ucpd_rx_pkg::ordset_e got,
                              input ucpd_rx_pkg::ordset_e exp);
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s got %s expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_idx(input string name, input ucpd_rx_pkg::corrupt_idx_t got,
                           input ucpd_rx_pkg::corrupt_idx_t exp);
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [PAYSIZE_W-1:0] got,
                             input logic [PAYSIZE_W-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // reads every byte as soon as rxne rises
  task automatic read_bytes(input ucpd_rx_pkg::byte_t exp[$]);
    int n;
    foreach (exp[i])
    begin
      n = 0;
      while (!rxne && n < (SET_BITS + 20) * BIT_CYCLES)  // first byte follows the set
      begin
        wait_cycles(1);
        n++;
      end
      if (!rxne)
      begin
        $display("byte %0d of the message never reached the data register", i);
        errors++;
        return;
      end
      check_byte("rxdr", rxdr, exp[i]);
      read_rxdr();
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic clean_message();
    ucpd_rx_pkg::byte_t   data[$];
    ucpd_rx_pkg::symbol_t ks[4];
    int                   ord_base;
    int                   end_base;
    for (int i = 0; i < 8; i++)
      data.push_back(next_byte());
    ordset_codes(ucpd_rx_pkg::ORD_SOP, ks);
    idle_line();
    ord_base = ordset_cnt;
    end_base = end_cnt;
    fork
      begin
        send_ordset(ks);
        foreach (data[i])
          send_byte(data[i]);
        send_symbol(ucpd_rx_pkg::K_EOP);
      end
      read_bytes(data);
    join
    wait_cycles(5);
    check_flag("ordset_vld seen", ordset_cnt != ord_base, 1'b1);
    check_ordset("ordset_type", ordset_type, ucpd_rx_pkg::ORD_SOP);
    check_idx("sop_corrupt_idx", sop_corrupt_idx, 3'd0);
    check_flag("msg_end seen", end_cnt != end_base, 1'b1);
    check_count("paysize", paysize, 10'd8);
  endtask

  task automatic ordset_corruption();
    ucpd_rx_pkg::symbol_t ks[4];
    int                   base;
    ordset_en = '1;
    for (int t = 0; t < 5; t++)
    begin
      ordset_codes(ucpd_rx_pkg::ordset_e'(t), ks);
      ks[t % 4] = ucpd_rx_pkg::encode_4b5b(4'h0);
      idle_line();
      base = ordset_cnt;
      send_ordset(ks);
      wait_cycles(5);
      check_flag("ordset_vld seen", ordset_cnt != base, 1'b1);
      check_ordset("ordset_type", ordset_type, ucpd_rx_pkg::ordset_e'(t));
      check_idx("sop_corrupt_idx", sop_corrupt_idx, 3'(t % 4 + 1));
    end
    ordset_en = 6'b111101;  // SOP' disabled
    ordset_codes(ucpd_rx_pkg::ORD_SOP1, ks);
    idle_line();
    base = ordset_cnt;
    send_ordset(ks);
    send_byte(8'h00);  // must not be decoded
    wait_cycles(5);
    check_flag("ordset_vld seen", ordset_cnt != base, 1'b0);
    check_flag("rxne", rxne, 1'b0);
    ordset_en = '1;
  endtask

  task automatic reset_sets();
    ucpd_rx_pkg::symbol_t ks[4];
    int                   ord_base;
    int                   hrst_base;
    ordset_en = '0;
    ordset_codes(ucpd_rx_pkg::ORD_HARD_RST, ks);
    idle_line();
    ord_base  = ordset_cnt;
    hrst_base = hrst_cnt;
    send_ordset(ks);
    wait_cycles(5);
    check_flag("hrst_det seen", hrst_cnt != hrst_base, 1'b1);
    check_flag("ordset_vld seen", ordset_cnt != ord_base, 1'b0);
    ordset_en = 6'b100000;
    ordset_codes(ucpd_rx_pkg::ORD_CABLE_RST, ks);
    idle_line();
    ord_base = ordset_cnt;
    send_ordset(ks);
    send_byte(8'h00);  // must not be decoded
    wait_cycles(5);
    check_flag("ordset_vld seen", ordset_cnt != ord_base, 1'b1);
    check_ordset("ordset_type", ordset_type, ucpd_rx_pkg::ORD_CABLE_RST);
    check_flag("rxne", rxne, 1'b0);
    ordset_en = '1;
  endtask

  task automatic back_pressure();
    ucpd_rx_pkg::byte_t   data[3];
    ucpd_rx_pkg::symbol_t ks[4];
    int                   base;
    foreach (data[i])
      data[i] = next_byte();
    ordset_codes(ucpd_rx_pkg::ORD_SOP, ks);
    idle_line();
    base = ovf_cnt;
    send_ordset(ks);
    foreach (data[i])
      send_byte(data[i]);
    send_symbol(ucpd_rx_pkg::K_EOP);
    wait_cycles(5);
    check_count("rx_ovrflow pulses", PAYSIZE_W'(ovf_cnt - base), 10'd2);
    check_byte("rxdr", rxdr, data[0]);
    check_count("paysize", paysize, 10'd3);
    read_rxdr();
  endtask

  task automatic error_and_idle();
    ucpd_rx_pkg::symbol_t ks[4];
    ucpd_rx_pkg::byte_t   b;
    int                   end_base;
    int                   err_base;
    ordset_codes(ucpd_rx_pkg::ORD_SOP, ks);
    idle_line();
    end_base = end_cnt;
    err_base = data_err_cnt;
    send_ordset(ks);
    send_byte(next_byte());
    send_symbol(5'b00000);  // not in the 4b5b table
    wait_cycles(5);
    check_flag("rx_data_err seen", data_err_cnt != err_base, 1'b1);
    check_flag("msg_end seen", end_cnt != end_base, 1'b0);
    read_rxdr();
    // line goes idle after the low nibble of a byte
    idle_line();
    b = next_byte();
    send_ordset(ks);
    send_symbol(ucpd_rx_pkg::encode_4b5b(b[3:0]));
    idle_line();
    send_symbol(ucpd_rx_pkg::encode_4b5b(b[7:4]));
    send_symbol(ucpd_rx_pkg::K_EOP);
    wait_cycles(5);
    check_flag("msg_end seen", end_cnt != end_base, 1'b0);
    check_flag("rxne", rxne, 1'b0);
    clean_message();
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial
  begin
    ic_rst_n  = 1'b0;
    bit_valid = 1'b0;
    bit_data  = 1'b0;
    line_idle = 1'b0;
    ordset_en = '1;
    rxdr_rd   = 1'b0;
    repeat (3) @(posedge ucpd_clk);
    #2;
    ic_rst_n = 1'b1;
    wait_cycles(1);
    check_flag("rxne after reset", rxne, 1'b0);
    check_count("paysize after reset", paysize, 10'd0);
    clean_message();
    ordset_corruption();
    reset_sets();
    back_pressure();
    error_and_idle();
    wait_cycles(10);
    $display("checks done with %0d errors", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: compile.f
src/ucpd_rx_pkg.sv
src/ucpd_rx_kcode_window.sv
src/ucpd_rx_ordset_detect.sv
src/ucpd_rx_framer.sv
src/ucpd_rx_byte_assembler.sv
src/ucpd_rx_top.sv
bench/ucpd_rx_sva.sv
bench/tb_ucpd_rx.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_ucpd_rx
FILELIST  ?= compile.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
